/* hdl/ctrl_pkg.sv */
/* pipeline-control encodings shared by the controller units
   widths are fixed by RV32 with a 6-bit register address (FP regs included) */

package ctrl_pkg;

  localparam int REG_ADDR_W = 6;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // fetch stage PC source
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101
  } pc_mux_t;

  // operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_t;

  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_t;

  // decoder flags, held stable by the ID stage while it is halted
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic pipe_flush;
  } dec_flags_t;

  // destination equals source a, b or c
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } reg_match_t;

  typedef struct packed {
    logic      we_ex;
    logic      we_wb;
    logic      alu_we_fw;
    reg_addr_t waddr_ex;
    reg_addr_t alu_waddr_id;
  } rf_write_t;

  typedef struct packed {
    fw_sel_t sel_a;
    fw_sel_t sel_b;
    fw_sel_t sel_c;
  } fw_sel_bundle_t;

  typedef struct packed {
    logic    pc_set;
    pc_mux_t pc_mux;
  } pc_ctrl_t;

endpackage

/* hdl/trap_pkg.sv */
/* trap encodings for a machine-mode-only core
   cause top bit marks an interrupt, the low bits carry the code or irq id */

package trap_pkg;

  localparam int IRQ_ID_W = 5;
  localparam int CAUSE_W  = 6;

  typedef logic [IRQ_ID_W-1:0] irq_id_t;
  typedef logic [CAUSE_W-1:0]  cause_t;

  // standard RISC-V exception codes
  localparam cause_t EXC_CAUSE_ILLEGAL_INSN = 6'h02;
  localparam cause_t EXC_CAUSE_LOAD_FAULT   = 6'h05;
  localparam cause_t EXC_CAUSE_STORE_FAULT  = 6'h07;
  localparam cause_t EXC_CAUSE_ECALL_MMODE  = 6'h0B;

  // trap vector select, exception vector is the all-zero idle value
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,
    EXC_PC_IRQ       = 2'b01
  } exc_pc_t;

  // requests towards the CSR file
  typedef struct packed {
    logic   save_if;
    logic   save_id;
    logic   save_ex;
    logic   save_cause;
    logic   restore_mret;
    cause_t cause;
  } csr_ctrl_t;

  // handshakes towards the interrupt controller, LSU and fetch
  typedef struct packed {
    logic    exc_ack;
    logic    exc_kill;
    logic    irq_ack;
    logic    data_err_ack;
    exc_pc_t exc_pc_mux;
    cause_t  exc_cause;
  } trap_ctrl_t;

endpackage

/* hdl/ctrl_fsm.sv */
/* main control FSM, machine mode only, no debug support
   decoder flags must stay stable while ID is halted in the flush states */

`timescale 1ns/1ps

module ctrl_fsm
  import ctrl_pkg::*, trap_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       fetch_enable_i,
  input  logic       instr_valid_i,
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       branch_taken_ex_i,
  input  logic       data_err_i,
  input  logic       data_we_ex_i,
  input  logic       irq_i,
  input  logic       irq_req_ctrl_i,
  input  logic       m_ie_i,
  input  logic       jr_stall_i,
  input  dec_flags_t dec_i,
  input  jump_t      jump_in_dec_i,
  input  irq_id_t    irq_id_i,

  output logic       ctrl_busy_o,
  output logic       first_fetch_o,
  output logic       is_decoding_o,
  output logic       instr_req_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output pc_ctrl_t   pc_ctrl_o,
  output csr_ctrl_t  csr_ctrl_o,
  output trap_ctrl_t trap_ctrl_o
);

  typedef enum logic [3:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH_EX, FLUSH_WB,
    IRQ_FLUSH, IRQ_TAKEN_ID, IRQ_TAKEN_IF, WAIT_SLEEP, SLEEP
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   jump_done_q;
  logic   jump_done_d;
  logic   data_err_q;
  logic   jump_in_dec;
  logic   irq_take;
  cause_t fault_cause;

  // jal and jalr target is known in ID already
  assign jump_in_dec = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);
  // only the machine enable bit gates interrupts
  assign irq_take    = irq_req_ctrl_i & m_ie_i;
  assign fault_cause = data_we_ex_i ? EXC_CAUSE_STORE_FAULT : EXC_CAUSE_LOAD_FAULT;

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d       = state_q;
    jump_done_d   = jump_done_q;

    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    pc_ctrl_o.pc_set = 1'b0;
    pc_ctrl_o.pc_mux = PC_BOOT;
    csr_ctrl_o       = '0;
    // all-zero also selects the exception vector
    trap_ctrl_o      = '0;

    case (state_q)
      // hold the boot address until fetch is enabled
      RESET:
      begin
        instr_req_o      = 1'b0;
        pc_ctrl_o.pc_set = 1'b1;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into the prefetcher
      BOOT_SET:
      begin
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          state_d = DECODE;
        // pipeline is empty here, so the IF pc is the one to save
        if (irq_take)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN_IF;
        end
      end

      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX wins over anything in ID
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = PC_BRANCH;
        end
        else if (data_err_i)
        begin
          // faulting load/store in EX, vector one cycle later
          halt_if_o                = 1'b1;
          halt_id_o                = 1'b1;
          csr_ctrl_o.save_ex       = 1'b1;
          csr_ctrl_o.save_cause    = 1'b1;
          csr_ctrl_o.cause         = fault_cause;
          trap_ctrl_o.data_err_ack = 1'b1;
          state_d                  = FLUSH_WB;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (irq_take)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_FLUSH;
          end
          else if (jump_in_dec)
          begin
            pc_ctrl_o.pc_mux = PC_JUMP;
            // one pc_set per jump, and only once the jr source is ready
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_ctrl_o.pc_set = 1'b1;
              jump_done_d      = 1'b1;
            end
          end
          else if (dec_i.pipe_flush)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
          else if (dec_i.ecall || dec_i.illegal)
          begin
            halt_if_o             = 1'b1;
            halt_id_o             = 1'b1;
            csr_ctrl_o.save_id    = 1'b1;
            csr_ctrl_o.save_cause = 1'b1;
            csr_ctrl_o.cause      = dec_i.ecall ? EXC_CAUSE_ECALL_MMODE
                                                : EXC_CAUSE_ILLEGAL_INSN;
            state_d               = FLUSH_EX;
          end
          else if (dec_i.mret)
          begin
            halt_if_o               = 1'b1;
            halt_id_o               = 1'b1;
            csr_ctrl_o.restore_mret = 1'b1;
            state_d                 = FLUSH_EX;
          end
        end
      end

      // drain EX before touching the CSRs
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (data_err_i)
        begin
          csr_ctrl_o.save_ex       = 1'b1;
          csr_ctrl_o.save_cause    = 1'b1;
          csr_ctrl_o.cause         = fault_cause;
          trap_ctrl_o.data_err_ack = 1'b1;
          state_d                  = FLUSH_WB;
        end
        else if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // redirect fetch for the trap or return
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (data_err_q)
        begin
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = PC_EXCEPTION;
          trap_ctrl_o.exc_cause = fault_cause;
        end
        else if (dec_i.ecall || dec_i.illegal)
        begin
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = PC_EXCEPTION;
          if (dec_i.ecall)
            trap_ctrl_o.exc_cause = EXC_CAUSE_ECALL_MMODE;
        end
        else if (dec_i.mret)
        begin
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_mux = PC_MRET;
        end
        // wfi goes to sleep, everything else resumes decoding
        state_d = dec_i.pipe_flush ? WAIT_SLEEP : DECODE;
      end

      // recheck the request, it may have been withdrawn
      IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (irq_i && m_ie_i)
          state_d = IRQ_TAKEN_ID;
        else
        begin
          trap_ctrl_o.exc_kill = 1'b1;
          state_d              = DECODE;
        end
      end

      // both take paths differ only in which pc gets saved
      IRQ_TAKEN_ID, IRQ_TAKEN_IF:
      begin
        pc_ctrl_o.pc_set       = 1'b1;
        pc_ctrl_o.pc_mux       = PC_EXCEPTION;
        trap_ctrl_o.exc_pc_mux = EXC_PC_IRQ;
        trap_ctrl_o.exc_cause  = {1'b1, irq_id_i};
        trap_ctrl_o.irq_ack    = 1'b1;
        trap_ctrl_o.exc_ack    = 1'b1;
        csr_ctrl_o.save_id     = (state_q == IRQ_TAKEN_ID);
        csr_ctrl_o.save_if     = (state_q == IRQ_TAKEN_IF);
        csr_ctrl_o.save_cause  = 1'b1;
        csr_ctrl_o.cause       = {1'b1, irq_id_i};
        state_d                = DECODE;
      end

      // one idle cycle so the core reports not busy before sleeping
      WAIT_SLEEP, SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (state_q == WAIT_SLEEP)
          state_d = SLEEP;
        else if (irq_i)
          state_d = FIRST_FETCH;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
      data_err_q  <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // released once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
      data_err_q  <= data_err_i;
    end
  end

endmodule

/* hdl/stall_detect.sv */
/* load-use and jump-register hazard detection, purely combinational
   match inputs come from the ID stage register address comparators */

`timescale 1ns/1ps

module stall_detect
  import ctrl_pkg::*;
(
  input  logic       is_decoding_i,
  input  logic       data_req_ex_i,
  input  logic       wb_ready_i,
  input  logic       illegal_i,
  input  jump_t      jump_in_dec_i,
  input  rf_write_t  rf_i,
  input  reg_match_t match_ex_i,
  input  reg_match_t match_wb_i,
  input  reg_match_t match_alu_i,

  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o
);

  logic load_pending;
  logic src_hit;
  logic dst_hit;

  // load in EX, or a WB write that has not completed yet
  assign load_pending = (data_req_ex_i & rf_i.we_ex) | (~wb_ready_i & rf_i.we_wb);

  // any source of the decoded instruction hits the EX destination
  assign src_hit = match_ex_i.a | match_ex_i.b | match_ex_i.c;

  // write-after-write on the same destination
  assign dst_hit = (rf_i.waddr_ex == rf_i.alu_waddr_id);

  // only an instruction that is really in decode can be stalled
  assign load_stall_o = is_decoding_i & load_pending & (src_hit | dst_hit);

  // jalr target needs operand a, which must not be in flight
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &
                      ((rf_i.we_wb & match_wb_i.a) |
                       (rf_i.we_ex & match_ex_i.a) |
                       (rf_i.alu_we_fw & match_alu_i.a));

  // squash the write of anything that is not really being decoded
  assign deassert_we_o = load_stall_o | jr_stall_o | ~is_decoding_i | illegal_i;

endmodule

/* hdl/fwd_select.sv */
/* forwarding select for the three ID operands
   EX forward beats WB forward, misaligned and multicycle override both */

`timescale 1ns/1ps

module fwd_select
  import ctrl_pkg::*;
(
  input  rf_write_t      rf_i,
  input  reg_match_t     match_wb_i,
  input  reg_match_t     match_alu_i,
  input  logic           misaligned_i,
  input  logic           mult_multicycle_i,

  output fw_sel_bundle_t fw_sel_o
);

  // per-operand rule, the same for a, b and c
  function automatic fw_sel_t pick(input logic wb_hit, input logic alu_hit);
    fw_sel_t sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    // newer result from the ALU path wins
    if (alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  always_comb
  begin
    fw_sel_o.sel_a = pick(rf_i.we_wb & match_wb_i.a, rf_i.alu_we_fw & match_alu_i.a);
    fw_sel_o.sel_b = pick(rf_i.we_wb & match_wb_i.b, rf_i.alu_we_fw & match_alu_i.b);
    fw_sel_o.sel_c = pick(rf_i.we_wb & match_wb_i.c, rf_i.alu_we_fw & match_alu_i.c);

    // second half of a misaligned access reuses the EX address
    if (misaligned_i)
    begin
      fw_sel_o.sel_a = SEL_FW_EX;
      fw_sel_o.sel_b = SEL_REGFILE;
    end
    // multicycle multiply keeps its partial result on operand c
    else if (mult_multicycle_i)
    begin
      fw_sel_o.sel_c = SEL_FW_EX;
    end
  end

endmodule

/* hdl/core_controller.sv */
/* controller top, wires only
   FSM, stall detection and forwarding select share the decode-stage inputs */

`timescale 1ns/1ps

module core_controller
  import ctrl_pkg::*, trap_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,

  // FSM side
  input  logic           fetch_enable_i,
  input  logic           instr_valid_i,
  input  logic           id_ready_i,
  input  logic           ex_valid_i,
  input  logic           wb_ready_i,
  input  logic           branch_taken_ex_i,
  input  logic           data_req_ex_i,
  input  logic           data_err_i,
  input  logic           data_we_ex_i,
  input  logic           irq_i,
  input  logic           irq_req_ctrl_i,
  input  logic           m_ie_i,
  input  dec_flags_t     dec_i,
  input  jump_t          jump_in_dec_i,
  input  irq_id_t        irq_id_i,

  // hazard and forwarding side
  input  rf_write_t      rf_i,
  input  reg_match_t     match_ex_i,
  input  reg_match_t     match_wb_i,
  input  reg_match_t     match_alu_i,
  input  logic           misaligned_i,
  input  logic           mult_multicycle_i,

  output logic           ctrl_busy_o,
  output logic           first_fetch_o,
  output logic           is_decoding_o,
  output logic           instr_req_o,
  output logic           halt_if_o,
  output logic           halt_id_o,
  output pc_ctrl_t       pc_ctrl_o,
  output csr_ctrl_t      csr_ctrl_o,
  output trap_ctrl_t     trap_ctrl_o,
  output logic           load_stall_o,
  output logic           jr_stall_o,
  output logic           deassert_we_o,
  output fw_sel_bundle_t fw_sel_o
);

  ctrl_fsm ctrl_fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .data_err_i        (data_err_i),
    .data_we_ex_i      (data_we_ex_i),
    .irq_i             (irq_i),
    .irq_req_ctrl_i    (irq_req_ctrl_i),
    .m_ie_i            (m_ie_i),
    // jump pc_set waits on the hazard unit
    .jr_stall_i        (jr_stall_o),
    .dec_i             (dec_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .irq_id_i          (irq_id_i),
    .ctrl_busy_o       (ctrl_busy_o),
    .first_fetch_o     (first_fetch_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .pc_ctrl_o         (pc_ctrl_o),
    .csr_ctrl_o        (csr_ctrl_o),
    .trap_ctrl_o       (trap_ctrl_o)
  );

  stall_detect stall_detect_i (
    .is_decoding_i (is_decoding_o),
    .data_req_ex_i (data_req_ex_i),
    .wb_ready_i    (wb_ready_i),
    .illegal_i     (dec_i.illegal),
    .jump_in_dec_i (jump_in_dec_i),
    .rf_i          (rf_i),
    .match_ex_i    (match_ex_i),
    .match_wb_i    (match_wb_i),
    .match_alu_i   (match_alu_i),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o),
    .deassert_we_o (deassert_we_o)
  );

  fwd_select fwd_select_i (
    .rf_i              (rf_i),
    .match_wb_i        (match_wb_i),
    .match_alu_i       (match_alu_i),
    .misaligned_i      (misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fw_sel_o          (fw_sel_o)
  );

endmodule

/* tb/tb_clkgen.sv */
/* free-running 8 ns clock, reset held low over the first 4 rising edges
   reset is released 1 ns after an edge so it never races the flops */

`timescale 1ns/1ps

module tb_clkgen
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* tb/core_controller_tb.sv */
/* directed tests for the core controller, inputs change 1 ns after the rising edge
   outputs are sampled 6 ns after the edge, the run is cut off at 2000 cycles */

`timescale 1ns/1ps

module core_controller_tb
  import ctrl_pkg::*, trap_pkg::*;
();

  // all tests together take about 300 cycles
  localparam int MAX_CYCLES = 2000;

  logic           clk;
  logic           rst_n;
  logic           fetch_enable_i;
  logic           instr_valid_i;
  logic           id_ready_i;
  logic           ex_valid_i;
  logic           wb_ready_i;
  logic           branch_taken_ex_i;
  logic           data_req_ex_i;
  logic           data_err_i;
  logic           data_we_ex_i;
  logic           irq_i;
  logic           irq_req_ctrl_i;
  logic           m_ie_i;
  dec_flags_t     dec_i;
  jump_t          jump_in_dec_i;
  irq_id_t        irq_id_i;
  rf_write_t      rf_i;
  reg_match_t     match_ex_i;
  reg_match_t     match_wb_i;
  reg_match_t     match_alu_i;
  logic           misaligned_i;
  logic           mult_multicycle_i;

  logic           ctrl_busy_o;
  logic           first_fetch_o;
  logic           is_decoding_o;
  logic           instr_req_o;
  logic           halt_if_o;
  logic           halt_id_o;
  pc_ctrl_t       pc_ctrl_o;
  csr_ctrl_t      csr_ctrl_o;
  trap_ctrl_t     trap_ctrl_o;
  logic           load_stall_o;
  logic           jr_stall_o;
  logic           deassert_we_o;
  fw_sel_bundle_t fw_sel_o;

  int mismatches = 0;
  int failures   = 0;
  int cycle_cnt  = 0;

  tb_clkgen clkgen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_controller core_controller_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // timing and reporting helpers
  ////////////////////////////////////////////////////////////////////////////

  // next drive point, 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // from the drive point to the sample point
  task automatic settle();
    #5;
  endtask

  task automatic report_mismatch(input string test, input string sig,
                                 input logic [31:0] expected, input logic [31:0] actual);
    mismatches++;
    $display("MISMATCH %s %s expected %0h actual %0h at %0t",
             test, sig, expected, actual, $time);
  endtask

  task automatic report_failure(input string test, input string msg);
    failures++;
    $display("ERROR %s: %s at %0t", test, msg, $time);
  endtask

  // forwarding rule for one operand, ALU path newer than WB
  function automatic fw_sel_t operand_sel(input logic wb_hit, input logic alu_hit);
    if (alu_hit)
      return SEL_FW_EX;
    if (wb_hit)
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // tests, each starts and ends at a drive point
  ////////////////////////////////////////////////////////////////////////////

  task automatic boot_sequence();
    pc_ctrl_t boot_pc;
    boot_pc = '{pc_set: 1'b1, pc_mux: PC_BOOT};
    settle();
    if (instr_req_o !== 1'b0)
      report_mismatch("boot", "instr_req_o", 32'(1'b0), 32'(instr_req_o));
    tick();
    fetch_enable_i = 1'b1;
    tick();
    settle();
    if (instr_req_o !== 1'b1)
      report_mismatch("boot", "instr_req_o", 32'(1'b1), 32'(instr_req_o));
    if (pc_ctrl_o !== boot_pc)
      report_mismatch("boot", "pc_ctrl_o", 32'(boot_pc), 32'(pc_ctrl_o));
    tick();
    settle();
    if (first_fetch_o !== 1'b1)
      report_mismatch("boot", "first_fetch_o", 32'(1'b1), 32'(first_fetch_o));
    tick();
    // first instruction reaches ID one cycle late
    id_ready_i = 1'b1;
    tick();
    settle();
    if (is_decoding_o !== 1'b0)
      report_mismatch("boot", "is_decoding_o", 32'(1'b0), 32'(is_decoding_o));
    tick();
    instr_valid_i = 1'b1;
    settle();
    if (is_decoding_o !== 1'b1)
      report_mismatch("boot", "is_decoding_o", 32'(1'b1), 32'(is_decoding_o));
    tick();
  endtask

  task automatic forwarding_random();
    logic [31:0]    r;
    fw_sel_bundle_t expected;
    repeat (200)
    begin
      r = $urandom;
      rf_i.we_wb        = r[0];
      rf_i.alu_we_fw    = r[1];
      match_wb_i        = r[4:2];
      match_alu_i       = r[7:5];
      // overrides are rare in a real pipe
      misaligned_i      = (r[10:8] == 3'd0);
      mult_multicycle_i = (r[13:11] == 3'd0);
      expected.sel_a = operand_sel(rf_i.we_wb & match_wb_i.a, rf_i.alu_we_fw & match_alu_i.a);
      expected.sel_b = operand_sel(rf_i.we_wb & match_wb_i.b, rf_i.alu_we_fw & match_alu_i.b);
      expected.sel_c = operand_sel(rf_i.we_wb & match_wb_i.c, rf_i.alu_we_fw & match_alu_i.c);
      if (misaligned_i)
      begin
        expected.sel_a = SEL_FW_EX;
        expected.sel_b = SEL_REGFILE;
      end
      else if (mult_multicycle_i)
        expected.sel_c = SEL_FW_EX;
      settle();
      if (fw_sel_o !== expected)
        report_mismatch("forwarding", "fw_sel_o", 32'(expected), 32'(fw_sel_o));
      tick();
    end
    rf_i              = '0;
    match_wb_i        = '0;
    match_alu_i       = '0;
    misaligned_i      = 1'b0;
    mult_multicycle_i = 1'b0;
  endtask

  task automatic stall_cases();
    int pc_sets;
    // load in EX writes source a of the decoded instruction
    rf_i.we_ex        = 1'b1;
    rf_i.waddr_ex     = 6'd5;
    rf_i.alu_waddr_id = 6'd7;
    data_req_ex_i     = 1'b1;
    match_ex_i        = '{a: 1'b1, default: 1'b0};
    settle();
    if ({load_stall_o, jr_stall_o, deassert_we_o} !== 3'b101)
      report_mismatch("load_use", "stalls", 32'(3'b101),
                      32'({load_stall_o, jr_stall_o, deassert_we_o}));
    tick();
    // same match from an ALU result, no hazard
    data_req_ex_i = 1'b0;
    settle();
    if ({load_stall_o, jr_stall_o, deassert_we_o} !== 3'b000)
      report_mismatch("no_stall", "stalls", 32'(3'b000),
                      32'({load_stall_o, jr_stall_o, deassert_we_o}));
    tick();
    // jalr base register still in EX, back-pressure from ID
    id_ready_i    = 1'b0;
    jump_in_dec_i = BRANCH_JALR;
    repeat (3)
    begin
      settle();
      if ({load_stall_o, jr_stall_o, deassert_we_o} !== 3'b011)
        report_mismatch("jalr", "stalls", 32'(3'b011),
                        32'({load_stall_o, jr_stall_o, deassert_we_o}));
      if (pc_ctrl_o.pc_set !== 1'b0)
        report_mismatch("jalr", "pc_set", 32'(1'b0), 32'(pc_ctrl_o.pc_set));
      tick();
    end
    // base register written, the jump may go exactly once
    rf_i.we_ex = 1'b0;
    match_ex_i = '0;
    pc_sets    = 0;
    repeat (5)
    begin
      settle();
      if (pc_ctrl_o.pc_set === 1'b1)
      begin
        pc_sets++;
        if (pc_ctrl_o.pc_mux !== PC_JUMP)
          report_mismatch("jalr", "pc_mux", 32'(PC_JUMP), 32'(pc_ctrl_o.pc_mux));
      end
      tick();
    end
    // ID takes the jump now
    id_ready_i = 1'b1;
    settle();
    if (pc_ctrl_o.pc_set === 1'b1)
      pc_sets++;
    if (pc_sets != 1)
      report_mismatch("jalr", "pc_set count", 32'(1), 32'(pc_sets));
    tick();
    jump_in_dec_i = BRANCH_NONE;
    rf_i          = '0;
  endtask

  // one trap from DECODE through FLUSH_EX and FLUSH_WB back to DECODE
  task automatic trap_flow(input string name, input dec_flags_t flags, input logic data_err,
                           input csr_ctrl_t exp_csr, input pc_ctrl_t exp_pc,
                           input logic check_cause, input cause_t exp_cause);
    int n;
    dec_i        = flags;
    data_err_i   = data_err;
    // a data error is always a store here
    data_we_ex_i = data_err;
    settle();
    if (csr_ctrl_o !== exp_csr)
      report_mismatch(name, "csr_ctrl_o", 32'(exp_csr), 32'(csr_ctrl_o));
    if (halt_if_o !== 1'b1 || halt_id_o !== 1'b1)
      report_failure(name, "IF and ID were not halted");
    if (trap_ctrl_o.data_err_ack !== data_err)
      report_mismatch(name, "data_err_ack", 32'(data_err), 32'(trap_ctrl_o.data_err_ack));
    tick();
    data_err_i = 1'b0;
    if (!data_err)
    begin
      // EX still busy for a while
      repeat (2)
      begin
        settle();
        if (pc_ctrl_o.pc_set !== 1'b0)
          report_mismatch(name, "pc_set", 32'(1'b0), 32'(pc_ctrl_o.pc_set));
        tick();
      end
      ex_valid_i = 1'b1;
    end
    n = 0;
    settle();
    while (pc_ctrl_o.pc_set !== 1'b1 && n < 8)
    begin
      tick();
      settle();
      n++;
    end
    if (pc_ctrl_o.pc_set !== 1'b1)
      report_failure(name, "no pc_set after EX drained");
    else
    begin
      if (pc_ctrl_o !== exp_pc)
        report_mismatch(name, "pc_ctrl_o", 32'(exp_pc), 32'(pc_ctrl_o));
      if (exp_pc.pc_mux == PC_EXCEPTION && trap_ctrl_o.exc_pc_mux !== EXC_PC_EXCEPTION)
        report_mismatch(name, "exc_pc_mux", 32'(EXC_PC_EXCEPTION),
                        32'(trap_ctrl_o.exc_pc_mux));
      if (check_cause && trap_ctrl_o.exc_cause !== exp_cause)
        report_mismatch(name, "exc_cause", 32'(exp_cause), 32'(trap_ctrl_o.exc_cause));
    end
    tick();
    dec_i        = '0;
    ex_valid_i   = 1'b0;
    data_we_ex_i = 1'b0;
    settle();
    if (pc_ctrl_o.pc_set !== 1'b0 || halt_id_o !== 1'b0)
      report_failure(name, "controller did not return to decoding after one pc_set");
    tick();
  endtask

  task automatic exception_tests();
    csr_ctrl_t  exp_csr;
    dec_flags_t flags;
    pc_ctrl_t   exc_pc;
    pc_ctrl_t   mret_pc;
    exc_pc  = '{pc_set: 1'b1, pc_mux: PC_EXCEPTION};
    mret_pc = '{pc_set: 1'b1, pc_mux: PC_MRET};

    flags   = '{ecall: 1'b1, default: 1'b0};
    exp_csr = '{save_id: 1'b1, save_cause: 1'b1, cause: EXC_CAUSE_ECALL_MMODE, default: '0};
    trap_flow("ecall", flags, 1'b0, exp_csr, exc_pc, 1'b1, EXC_CAUSE_ECALL_MMODE);

    flags   = '{illegal: 1'b1, default: 1'b0};
    exp_csr = '{save_id: 1'b1, save_cause: 1'b1, cause: EXC_CAUSE_ILLEGAL_INSN, default: '0};
    trap_flow("illegal", flags, 1'b0, exp_csr, exc_pc, 1'b0, '0);

    flags   = '{mret: 1'b1, default: 1'b0};
    exp_csr = '{restore_mret: 1'b1, default: '0};
    trap_flow("mret", flags, 1'b0, exp_csr, mret_pc, 1'b0, '0);

    flags   = '0;
    exp_csr = '{save_ex: 1'b1, save_cause: 1'b1, cause: EXC_CAUSE_STORE_FAULT, default: '0};
    trap_flow("store_fault", flags, 1'b1, exp_csr, exc_pc, 1'b1, EXC_CAUSE_STORE_FAULT);
  endtask

  task automatic irq_entry();
    logic [31:0] r;
    irq_id_t     id;
    csr_ctrl_t   exp_csr;
    pc_ctrl_t    exp_pc;
    trap_ctrl_t  exp_trap;
    r        = $urandom;
    id       = r[4:0];
    exp_csr  = '{save_id: 1'b1, save_cause: 1'b1, cause: {1'b1, id}, default: '0};
    exp_pc   = '{pc_set: 1'b1, pc_mux: PC_EXCEPTION};
    exp_trap = '{exc_ack: 1'b1, irq_ack: 1'b1, exc_pc_mux: EXC_PC_IRQ,
                 exc_cause: {1'b1, id}, default: '0};
    irq_id_i       = id;
    irq_req_ctrl_i = 1'b1;
    irq_i          = 1'b1;
    m_ie_i         = 1'b1;
    settle();
    if (halt_id_o !== 1'b1)
      report_mismatch("irq", "halt_id_o", 32'(1'b1), 32'(halt_id_o));
    tick();
    settle();
    if (trap_ctrl_o.irq_ack !== 1'b0)
      report_failure("irq", "irq_ack came one cycle early");
    tick();
    settle();
    if (trap_ctrl_o.irq_ack !== 1'b1 || trap_ctrl_o.exc_ack !== 1'b1)
      report_failure("irq", "irq_ack and exc_ack missing two cycles after the request");
    if (trap_ctrl_o !== exp_trap)
      report_mismatch("irq", "trap_ctrl_o", 32'(exp_trap), 32'(trap_ctrl_o));
    if (pc_ctrl_o !== exp_pc)
      report_mismatch("irq", "pc_ctrl_o", 32'(exp_pc), 32'(pc_ctrl_o));
    if (csr_ctrl_o !== exp_csr)
      report_mismatch("irq", "csr_ctrl_o", 32'(exp_csr), 32'(csr_ctrl_o));
    tick();
    // request stays, but machine interrupts are masked
    m_ie_i = 1'b0;
    repeat (4)
    begin
      settle();
      if (trap_ctrl_o.irq_ack !== 1'b0 || halt_id_o !== 1'b0)
        report_failure("irq_masked", "masked interrupt was taken");
      tick();
    end
    irq_req_ctrl_i = 1'b0;
    irq_i          = 1'b0;
  endtask

  task automatic sleep_wakeup();
    int n;
    dec_i.pipe_flush = 1'b1;
    settle();
    if (halt_if_o !== 1'b1)
      report_mismatch("sleep", "halt_if_o", 32'(1'b1), 32'(halt_if_o));
    tick();
    ex_valid_i = 1'b1;
    n = 0;
    settle();
    while (ctrl_busy_o !== 1'b0 && n < 8)
    begin
      tick();
      settle();
      n++;
    end
    if (ctrl_busy_o !== 1'b0)
      report_failure("sleep", "core stayed busy after the pipe flush");
    if (instr_req_o !== 1'b0)
      report_mismatch("sleep", "instr_req_o", 32'(1'b0), 32'(instr_req_o));
    tick();
    dec_i      = '0;
    ex_valid_i = 1'b0;
    repeat (3)
    begin
      settle();
      if (ctrl_busy_o !== 1'b0 || instr_req_o !== 1'b0)
        report_failure("sleep", "core left sleep without an interrupt");
      tick();
    end
    // wake-up goes through the first-fetch stage
    irq_i = 1'b1;
    n = 0;
    settle();
    while (first_fetch_o !== 1'b1 && n < 8)
    begin
      tick();
      settle();
      n++;
    end
    if (first_fetch_o !== 1'b1)
      report_failure("sleep", "interrupt did not wake the core");
    tick();
    irq_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    fetch_enable_i    = 1'b0;
    instr_valid_i     = 1'b0;
    id_ready_i        = 1'b0;
    ex_valid_i        = 1'b0;
    wb_ready_i        = 1'b1;
    branch_taken_ex_i = 1'b0;
    data_req_ex_i     = 1'b0;
    data_err_i        = 1'b0;
    data_we_ex_i      = 1'b0;
    irq_i             = 1'b0;
    irq_req_ctrl_i    = 1'b0;
    m_ie_i            = 1'b0;
    dec_i             = '0;
    jump_in_dec_i     = BRANCH_NONE;
    irq_id_i          = '0;
    rf_i              = '0;
    match_ex_i        = '0;
    match_wb_i        = '0;
    match_alu_i       = '0;
    misaligned_i      = 1'b0;
    mult_multicycle_i = 1'b0;
    void'($urandom(32'h5d3b));

    @(posedge rst_n);
    tick();

    boot_sequence();
    forwarding_random();
    stall_cases();
    exception_tests();
    irq_entry();
    sleep_wakeup();

    $display("%0d mismatches, %0d other errors, %0d cycles", mismatches, failures, cycle_cnt);
    if (mismatches + failures == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* compile.f */
hdl/ctrl_pkg.sv
hdl/trap_pkg.sv
hdl/ctrl_fsm.sv
hdl/stall_detect.sv
hdl/fwd_select.sv
hdl/core_controller.sv
tb/tb_clkgen.sv
tb/core_controller_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module core_controller_tb -f compile.f &&
./obj_dir/Vcore_controller_tb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
